// File: rtl/bs_pkg.sv
// Shared widths, enums and structs for the Black-Scholes put-payoff engine; import into each RTL module.
`default_nettype none

package bs_pkg;

	// Fraction bits on every port value.
	localparam int FRAC_W = 15;
	// Strike and payoff, (8,15).
	localparam int K_W = 23;
	// Drifted spot price S*exp((r-sigma^2/2)T), (23,15).
	localparam int C1_W = 38;
	// Sigma*sqrt(T), (3,15).
	localparam int C2_W = 18;
	// Normal sample, (5,15).
	localparam int GRN_W = 20;
	// Result sums, (49,15).
	localparam int ACC_W = 64;
	// Exponential table entry, (9,31).
	localparam int LUT_OUT_W = 40;
	// Issue to accumulation, in cycles.
	localparam int PIPE_DEPTH = 5;

	// Scaled sample, (8,30).
	localparam int SCALED_W = GRN_W + C2_W;
	// Correction factor 1 + f, (2,15).
	localparam int CORR_W = 17;
	// Approximated exponential, (11,46).
	localparam int EXP_W = LUT_OUT_W + CORR_W;
	// Price product, (34,61).
	localparam int PRICE_W = EXP_W + C1_W;
	localparam int PRICE_FRAC_W = 31 + 2 * FRAC_W;

	typedef enum logic [3:0] {
		IDLE = 4'd0,
		RUNNING = 4'd1,
		COMPLETE = 4'd2
	} state_t;

	typedef enum logic [3:0] {
		CMD_NOP = 4'd0,
		CMD_RUN = 4'd1,
		CMD_ACK = 4'd2
	} cmd_t;

	// Class of the scaled sample's integer part.
	typedef enum logic [1:0] {
		RANGE_HIGH = 2'd0,
		RANGE_MID = 2'd1,
		RANGE_LOW = 2'd2
	} range_t;

	typedef struct packed {
		logic [K_W-1:0] k;
		logic [C1_W-1:0] c1;
		logic [C2_W-1:0] c2;
		logic [GRN_W-1:0] grn;
	} bs_consts_t;

	typedef struct packed {
		logic valid;
		range_t cls;
		logic [PRICE_W-1:0] price;
	} sample_t;

	typedef struct packed {
		logic valid;
		logic [K_W-1:0] value;
		logic [2*K_W-1:0] square;
	} payoff_t;

endpackage

`default_nettype wire

// File: rtl/exp_lut.sv
// Combinational e^x table over (6,2) arguments from -21.25 to 5.0, giving (9,31) results.
`default_nettype none

module exp_lut (
	input wire logic [7:0] arg,
	output logic [bs_pkg::LUT_OUT_W-1:0] value
);
	import bs_pkg::*;

	// Arguments 0.0 to 5.0 in steps of 0.25.
	localparam logic [LUT_OUT_W-1:0] POS_TAB [0:20] = '{
		40'h0080000000, 40'h00A45AF1E1, 40'h00D3094C70, 40'h010EF9DB46,
		40'h015BF0A8B1, 40'h01BEC38EDB, 40'h023DA7FCC9, 40'h02E096D20B,
		40'h03B1CC971A, 40'h04BE6E20BD, 40'h06175BF64C, 40'h07D241C2F6,
		40'h0A0AF2DFB7, 40'h0CE529DBC0, 40'h108EC72139, 40'h1542B2D0A2,
		40'h1B4C902E27, 40'h230D7E26DA, 40'h2D02315BC3, 40'h39CAC9D5DB,
		40'h4A34E265C0
	};

	// Arguments -21.25 (code 0xAB) to -0.25 (code 0xFF).
	localparam logic [LUT_OUT_W-1:0] NEG_TAB [0:84] = '{
		40'h1, 40'h1, 40'h2, 40'h2, 40'h3,
		40'h4, 40'h5, 40'h7, 40'h9, 40'hC, 40'hF,
		40'h13, 40'h19, 40'h20, 40'h29, 40'h35, 40'h45,
		40'h58, 40'h72, 40'h92, 40'hBC,
		40'hF1, 40'h136, 40'h18E, 40'h1FF, 40'h290, 40'h34B,
		40'h43B, 40'h56E, 40'h6F9, 40'h8F4, 40'hB80, 40'hEC4,
		40'h12F6, 40'h1858, 40'h1F42, 40'h2823,
		40'h338A, 40'h422E, 40'h54FA, 40'h6D1C, 40'h8C1A, 40'hB3E5,
		40'hE6FE, 40'h12899, 40'h17CD7, 40'h1E902, 40'h273E7, 40'h3263E,
		40'h40B3C, 40'h53145, 40'h6AAD0, 40'h88F98,
		40'hAFE10, 40'hE1D54, 40'h121F9B, 40'h17455F, 40'h1DE16B, 40'h265E0C,
		40'h3143C3, 40'h3F41D2, 40'h513947, 40'h684B19, 40'h85EA52, 40'hABF35F,
		40'hDCC9FF, 40'h11B7FAD, 40'h16C0504, 40'h1D36911,
		40'h2582AB7, 40'h302A126, 40'h3DD8203, 40'h4F68DA1, 40'h65F6C33, 40'h82EC9C4,
		40'hA81C2E0, 40'hD7DB8C7, 40'h1152AAA3, 40'h163E397E, 40'h1C8F8772, 40'h24AC306E,
		40'h2F16AC6C, 40'h3C7681D7, 40'h4DA2CBF1, 40'h63AFBE7A
	};

	logic [7:0] neg_idx;

	// Offset of a negative code into its table.
	assign neg_idx = arg - 8'hAB;

	always_comb begin
		value = '0;
		if (arg <= 8'd20) begin
			value = POS_TAB[arg[4:0]];
		end else if (arg >= 8'hAB) begin
			value = NEG_TAB[neg_idx[6:0]];
		end
		// Codes between the two ranges stay zero.
	end

endmodule

`default_nettype wire

// File: rtl/path_sampler.sv
// Three-stage price path: scale the sample, approximate its exponential, then multiply by c1.
`default_nettype none

module path_sampler (
	input wire logic clk,
	input wire logic nreset,
	input wire bs_pkg::bs_consts_t consts,
	input wire logic issue,
	output bs_pkg::sample_t sample
);
	import bs_pkg::*;

	logic signed [SCALED_W:0] scale_prod;
	logic [SCALED_W-1:0] scaled_q;
	logic signed [7:0] int_part;
	range_t cls_d;
	logic [7:0] lut_arg;
	logic [LUT_OUT_W-1:0] lut_value;
	logic [CORR_W-1:0] corr;
	logic [EXP_W-1:0] exp_q;
	logic [PRICE_W-1:0] price_q;
	range_t cls_q1;
	range_t cls_q2;
	logic v1;
	logic v2;
	logic v3;

	// Signed sample times non-negative sigma*sqrt(T).
	assign scale_prod = $signed(consts.grn) * $signed({1'b0, consts.c2});

	// Stage 1, scaling multiply.
	always_ff @(posedge clk) begin
		scaled_q <= scale_prod[SCALED_W-1:0];
	end

	// Integer part of the (8,30) scaled value.
	assign int_part = $signed(scaled_q[SCALED_W-1 -: 8]);

	always_comb begin
		if (int_part >= 8'sd5) begin
			cls_d = RANGE_HIGH;
		end else if (int_part < -8'sd19) begin
			cls_d = RANGE_LOW;
		end else begin
			cls_d = RANGE_MID;
		end
	end

	// Six integer bits and two fraction bits.
	assign lut_arg = scaled_q[2*FRAC_W+5 -: 8];

	exp_lut exp_lut_i (
		.arg(lut_arg),
		.value(lut_value)
	);

	// One plus the 13 leftover fraction bits, e^f ~ 1 + f.
	assign corr = {2'b01, 2'b00, scaled_q[2*FRAC_W-3:FRAC_W]};

	// Stage 2 exponential, stage 3 price.
	always_ff @(posedge clk) begin
		exp_q <= lut_value * corr;
		price_q <= exp_q * consts.c1;
		cls_q1 <= cls_d;
		cls_q2 <= cls_q1;
	end

	// Valid follows the data through all three stages.
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else begin
			v1 <= issue;
			v2 <= v1;
			v3 <= v2;
		end
	end

	assign sample.valid = v3;
	assign sample.cls = cls_q2;
	assign sample.price = price_q;

endmodule

`default_nettype wire

// File: rtl/payoff_stage.sv
// Two-stage put payoff: clamp the price against the strike, subtract from K, then square.
`default_nettype none

module payoff_stage (
	input wire logic clk,
	input wire logic nreset,
	input wire logic [bs_pkg::K_W-1:0] k,
	input wire bs_pkg::sample_t sample,
	output bs_pkg::payoff_t payoff
);
	import bs_pkg::*;

	logic [PRICE_W-PRICE_FRAC_W+FRAC_W-1:0] price_hi;
	logic [K_W-1:0] amount;
	logic [K_W-1:0] value_q;
	logic [K_W-1:0] value_q2;
	logic [2*K_W-1:0] square_q;
	logic va;
	logic vb;

	// Price in (34,15).
	assign price_hi = sample.price[PRICE_W-1:PRICE_FRAC_W-FRAC_W];

	always_comb begin
		if (sample.cls == RANGE_LOW) begin
			amount = '0;
		end else if (sample.cls == RANGE_HIGH || price_hi >= k) begin
			amount = k;
		end else begin
			amount = price_hi[K_W-1:0];
		end
	end

	// Subtraction, then square with the value kept in step.
	always_ff @(posedge clk) begin
		value_q <= k - amount;
		value_q2 <= value_q;
		square_q <= value_q * value_q;
	end

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			va <= 1'b0;
			vb <= 1'b0;
		end else begin
			va <= sample.valid;
			vb <= va;
		end
	end

	assign payoff.valid = vb;
	assign payoff.value = value_q2;
	assign payoff.square = square_q;

	// A put payoff never exceeds its strike.
	a_payoff_le_k: assert property (@(posedge clk) disable iff (!nreset)
		va |-> value_q <= k);

endmodule

`default_nettype wire

// File: rtl/run_control.sv
// Command FSM: captures run constants while idle, issues iterations and tracks completion.
`default_nettype none

module run_control #(
	parameter int NITER_W = 32
) (
	input wire logic clk,
	input wire logic nreset,
	input wire bs_pkg::cmd_t cmd,
	input wire logic [NITER_W-1:0] niter,
	input wire logic [bs_pkg::K_W-1:0] k,
	input wire logic [bs_pkg::C1_W-1:0] c1,
	input wire logic [bs_pkg::C2_W-1:0] c2,
	input wire logic [bs_pkg::GRN_W-1:0] grn,
	output bs_pkg::bs_consts_t consts,
	output logic issue,
	output logic clear,
	output bs_pkg::state_t status
);
	import bs_pkg::*;

	state_t state;
	logic [NITER_W-1:0] niter_q;
	logic [NITER_W-1:0] issued;
	logic [NITER_W:0] cycles;
	logic [NITER_W:0] last_cycle;

	// Constants follow the inputs until a run starts.
	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			consts <= '{k: k, c1: c1, c2: c2, grn: grn};
			niter_q <= niter;
		end
	end

	// Last cycle count before the final payoff lands.
	assign last_cycle = {1'b0, niter_q} + (NITER_W+1)'(PIPE_DEPTH - 1);
	assign issue = (state == RUNNING) && (issued != niter_q);
	assign clear = (state == IDLE) && (cmd == CMD_RUN);
	assign status = state;

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			state <= IDLE;
			issued <= '0;
			cycles <= '0;
		end else begin
			case (state)
				IDLE: begin
					issued <= '0;
					cycles <= '0;
					if (cmd == CMD_RUN) begin
						state <= RUNNING;
					end
				end
				RUNNING: begin
					// Commands are ignored here.
					cycles <= cycles + 1'b1;
					if (issue) begin
						issued <= issued + 1'b1;
					end
					if (cycles == last_cycle) begin
						state <= COMPLETE;
					end
				end
				COMPLETE: begin
					if (cmd == CMD_ACK) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// An issued iteration is still in flight for the full pipeline depth.
	a_issue_running: assert property (@(posedge clk) disable iff (!nreset)
		issue |-> (state == RUNNING) [*PIPE_DEPTH+1]);

endmodule

`default_nettype wire

// File: rtl/moment_accumulator.sv
// Running sum and sum of squares of payoffs, cleared at the start of each run.
`default_nettype none

module moment_accumulator (
	input wire logic clk,
	input wire logic nreset,
	input wire logic clear,
	input wire bs_pkg::payoff_t payoff,
	output logic [bs_pkg::ACC_W-1:0] sum,
	output logic [bs_pkg::ACC_W-1:0] pow_sum
);
	import bs_pkg::*;

	// Square realigned from (16,30) to (16,15).
	logic [2*K_W-FRAC_W-1:0] square_rs;

	assign square_rs = payoff.square[2*K_W-1:FRAC_W];

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			sum <= '0;
			pow_sum <= '0;
		end else if (clear) begin
			sum <= '0;
			pow_sum <= '0;
		end else if (payoff.valid) begin
			sum <= sum + ACC_W'(payoff.value);
			pow_sum <= pow_sum + ACC_W'(square_rs);
		end
	end

	// A run never starts while payoffs from the last one drain.
	a_clear_idle: assert property (@(posedge clk) disable iff (!nreset)
		!(clear && payoff.valid));

endmodule

`default_nettype wire

// File: rtl/bs_processor.sv
// Top level of the put-payoff engine; connects control, price pipeline and accumulator.
`default_nettype none

module bs_processor #(
	parameter int NITER_W = 32
) (
	input wire logic clk,
	input wire logic nreset,
	input wire bs_pkg::cmd_t cmd,
	input wire logic [NITER_W-1:0] niter,
	input wire logic [bs_pkg::K_W-1:0] k,
	input wire logic [bs_pkg::C1_W-1:0] c1,
	input wire logic [bs_pkg::C2_W-1:0] c2,
	input wire logic [bs_pkg::GRN_W-1:0] grn,
	output bs_pkg::state_t status,
	output logic [bs_pkg::ACC_W-1:0] sum,
	output logic [bs_pkg::ACC_W-1:0] pow_sum
);
	import bs_pkg::*;

	bs_consts_t consts;
	logic issue;
	logic clear;
	sample_t sample;
	payoff_t payoff;

	run_control #(.NITER_W(NITER_W)) run_control_i (
		.clk(clk), .nreset(nreset), .cmd(cmd), .niter(niter),
		.k(k), .c1(c1), .c2(c2), .grn(grn),
		.consts(consts), .issue(issue), .clear(clear), .status(status)
	);

	path_sampler path_sampler_i (
		.clk(clk), .nreset(nreset), .consts(consts), .issue(issue), .sample(sample)
	);

	// Strike comes from the captured run constants.
	payoff_stage payoff_stage_i (
		.clk(clk), .nreset(nreset), .k(consts.k), .sample(sample), .payoff(payoff)
	);

	moment_accumulator moment_accumulator_i (
		.clk(clk), .nreset(nreset), .clear(clear), .payoff(payoff),
		.sum(sum), .pow_sum(pow_sum)
	);

endmodule

`default_nettype wire

// File: test/bs_processor_tb.sv
// Testbench for the put-payoff engine; runs pricing scenarios and checks the results with assertions.
`default_nettype none

module bs_processor_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import bs_pkg::*;

	localparam int RESET_CYCLES = 8;
	// Iteration counts of the fixed scenarios.
	localparam int N_ITM = 10;
	localparam int N_ATK = 7;
	localparam int N_HIGH = 6;
	localparam int N_LOW = 9;
	localparam int N_HS = 12;
	localparam int N_RUNS = 7;

	// Strikes of 100.0 and 80.5 and the matching spot prices.
	localparam logic [K_W-1:0] K_A = 23'd3276800;
	localparam logic [K_W-1:0] K_B = 23'd2637824;
	localparam logic [C1_W-1:0] C1_ITM = 38'd2077081;
	localparam logic [C1_W-1:0] C1_HIGH = 38'd327680;
	localparam logic [C1_W-1:0] C1_B = 38'd1500000;
	// Strike 37.25 against a spot of 50.0.
	localparam logic [K_W-1:0] K_LOW = 23'd1220608;
	localparam logic [C1_W-1:0] C1_LOW = 38'd1638400;
	// Sigma*sqrt(T) of 1.0 and 2.0 and samples of 6.0 and -12.0.
	localparam logic [C2_W-1:0] C2_ONE = 18'd32768;
	localparam logic [C2_W-1:0] C2_TWO = 18'd65536;
	localparam logic [GRN_W-1:0] GRN_SIX = 20'h30000;
	localparam logic [GRN_W-1:0] GRN_M12 = 20'hA0000;
	// Zero volatility payoffs are K - c1.
	localparam logic [K_W-1:0] PAY_ITM = K_A - K_W'(C1_ITM);
	localparam logic [K_W-1:0] PAY_B = K_B - K_W'(C1_B);

	logic clk;
	logic nreset;
	cmd_t cmd;
	logic [31:0] niter;
	logic [K_W-1:0] k;
	logic [C1_W-1:0] c1;
	logic [C2_W-1:0] c2;
	logic [GRN_W-1:0] grn;
	state_t status;
	logic [ACC_W-1:0] sum;
	logic [ACC_W-1:0] pow_sum;

	// Expected results of the current run.
	logic [ACC_W-1:0] exp_sum;
	logic [ACC_W-1:0] exp_pow;
	int exp_cycles;
	int run_cycles;
	int errors;
	int errors_mark;
	int tests_run;
	int tests_failed;
	int cycle_count;
	int cycle_limit;
	int seed;
	int rand_niter;

	event reset_ev;
	event done_ev;
	event ignore_ev;
	event idle_ev;

	bs_processor #(.NITER_W(32)) dut_i (
		.clk(clk), .nreset(nreset), .cmd(cmd), .niter(niter),
		.k(k), .c1(c1), .c2(c2), .grn(grn),
		.status(status), .sum(sum), .pow_sum(pow_sum)
	);

	always #4 clk = ~clk;

	task automatic flag_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		errors++;
		$display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, expected,
			actual);
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	// Starts one run, disturbs the inputs while running and waits for COMPLETE.
	task automatic run_pricing(input int n, input logic [K_W-1:0] kv,
			input logic [C1_W-1:0] c1v, input logic [C2_W-1:0] c2v,
			input logic [GRN_W-1:0] grnv, input cmd_t noise, input logic [K_W-1:0] pay);
		logic [ACC_W-1:0] sq;
		niter = n;
		k = kv;
		c1 = c1v;
		c2 = c2v;
		grn = grnv;
		cmd = CMD_RUN;
		@(posedge clk);
		#1;
		// The captured run must not follow these.
		cmd = noise;
		niter = niter + 32'd3;
		k = ~kv;
		c1 = c1v + 38'd12345;
		run_cycles = 0;
		while (status == RUNNING) begin
			run_cycles++;
			@(posedge clk);
			#1;
		end
		cmd = CMD_NOP;
		// Every iteration of a run yields the same payoff.
		sq = ACC_W'(pay) * ACC_W'(pay);
		exp_sum = ACC_W'(n) * ACC_W'(pay);
		exp_pow = ACC_W'(n) * (sq >> FRAC_W);
		exp_cycles = n + PIPE_DEPTH;
		-> done_ev;
	endtask

	// ACK and one settling cycle in IDLE.
	task automatic acknowledge;
		cmd = CMD_ACK;
		@(posedge clk);
		#1;
		cmd = CMD_NOP;
		-> idle_ev;
		@(posedge clk);
		#1;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (errors != errors_mark) begin
			tests_failed++;
			$display("test %0d %s: FAILED, %0d checks", tests_run, name, errors - errors_mark);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		errors_mark = errors;
	endtask

	always @(reset_ev) begin
		assert (status == IDLE) else flag_mismatch("status", IDLE, status);
		assert (sum == '0) else flag_mismatch("sum", 0, sum);
		assert (pow_sum == '0) else flag_mismatch("pow_sum", 0, pow_sum);
	end

	always @(done_ev) begin
		assert (status == COMPLETE) else flag_mismatch("status", COMPLETE, status);
		assert (run_cycles == exp_cycles) else flag_mismatch("running cycles", exp_cycles,
			run_cycles);
		assert (sum == exp_sum) else flag_mismatch("sum", exp_sum, sum);
		assert (pow_sum == exp_pow) else flag_mismatch("pow_sum", exp_pow, pow_sum);
	end

	// CMD_RUN while complete changes nothing.
	always @(ignore_ev) begin
		assert (status == COMPLETE) else flag_mismatch("status", COMPLETE, status);
		assert (sum == exp_sum) else flag_mismatch("sum", exp_sum, sum);
		assert (pow_sum == exp_pow) else flag_mismatch("pow_sum", exp_pow, pow_sum);
	end

	always @(idle_ev) begin
		assert (status == IDLE) else flag_mismatch("status", IDLE, status);
	end

	// Only CMD_ACK leaves COMPLETE.
	a_complete_hold: assert property (@(posedge clk) disable iff (!nreset)
		(status == COMPLETE && cmd != CMD_ACK) |=> status == COMPLETE)
		else flag_mismatch("status", COMPLETE, status);

	a_ack_idle: assert property (@(posedge clk) disable iff (!nreset)
		(status == COMPLETE && cmd == CMD_ACK) |=> status == IDLE)
		else flag_mismatch("status", IDLE, status);

	a_run_ignores: assert property (@(posedge clk) disable iff (!nreset)
		(status == RUNNING && cmd != CMD_NOP) |=> status != IDLE)
		else report_error("a command during RUNNING sent the FSM back to IDLE");

	a_sums_held: assert property (@(posedge clk) disable iff (!nreset)
		status == COMPLETE |=> $stable(sum) && $stable(pow_sum))
		else report_error("a result sum changed while COMPLETE");

	// Watchdog.
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		nreset = 1'b0;
		cmd = CMD_NOP;
		niter = '0;
		k = '0;
		c1 = '0;
		c2 = '0;
		grn = '0;
		exp_sum = '0;
		exp_pow = '0;
		exp_cycles = 0;
		run_cycles = 0;
		errors = 0;
		errors_mark = 0;
		tests_run = 0;
		tests_failed = 0;
		cycle_count = 0;
		seed = 27248;
		rand_niter = ($random(seed) & 15) + 1;
		// Each run gets its length, the pipeline depth and ten cycles of slack.
		cycle_limit = RESET_CYCLES + N_ITM + N_ATK + N_HIGH + N_LOW + N_HS + rand_niter
			+ N_RUNS * (PIPE_DEPTH + 10);
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		nreset = 1'b1;
		-> reset_ev;
		@(posedge clk);
		#1;
		close_test("reset state");
		run_pricing(N_ITM, K_A, C1_ITM, '0, 20'h0F3A1, CMD_NOP, PAY_ITM);
		acknowledge();
		close_test("zero volatility in the money");
		run_pricing(N_ATK, K_A, C1_W'(K_A), '0, 20'h12345, CMD_NOP, '0);
		acknowledge();
		close_test("price at the strike");
		// The table gives 0 here and only the class keeps the payoff at 0.
		run_pricing(N_HIGH, K_A, C1_HIGH, C2_ONE, GRN_SIX, CMD_NOP, '0);
		acknowledge();
		close_test("high range sample");
		// Scaled sample of -24.0 with the spot above the strike.
		// The full strike needs the low class or a zero table entry.
		run_pricing(N_LOW, K_LOW, C1_LOW, C2_TWO, GRN_M12, CMD_NOP, K_LOW);
		acknowledge();
		close_test("deep negative sample");
		run_pricing(0, K_A, C1_ITM, '0, '0, CMD_NOP, PAY_ITM);
		acknowledge();
		close_test("zero iterations");
		// ACK held during RUNNING and CMD_RUN while complete.
		run_pricing(N_HS, K_B, C1_B, '0, '0, CMD_ACK, PAY_B);
		cmd = CMD_RUN;
		repeat (2) begin
			@(posedge clk);
			#1;
		end
		cmd = CMD_NOP;
		-> ignore_ev;
		acknowledge();
		// Random length rerun must start from cleared sums.
		run_pricing(rand_niter, K_B, C1_B, '0, '0, CMD_NOP, PAY_B);
		acknowledge();
		close_test("handshake and restart");
		$display("tests %0d, failed %0d, failed checks %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rtl/bs_pkg.sv
rtl/exp_lut.sv
rtl/path_sampler.sv
rtl/payoff_stage.sv
rtl/run_control.sv
rtl/moment_accumulator.sv
rtl/bs_processor.sv
test/bs_processor_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = bs_processor_tb
FILELIST = compile.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
